// ==== hw/dcache_pkg.sv ====
/*
 * Geometry and shared types for the two-way write-back data cache.
 * The CPU side works on 30-bit word addresses, so there are no byte enables.
 * A line is four 32-bit words, and there are 256 sets per way.
 * The struct widths follow the localparams. INDEX_W and OFFSET_W set the tag width.
 */
package dcache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam int WORD_ADDR_W    = 30;
    localparam int OFFSET_W       = 2;
    localparam int INDEX_W        = 8;
    localparam int TAG_W          = WORD_ADDR_W - INDEX_W - OFFSET_W;  // 20
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 1 << OFFSET_W;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;           // 128
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int LINE_ADDR_W    = WORD_ADDR_W - OFFSET_W;            // 28

    //////////////////////////////
    // port types
    //////////////////////////////
    typedef struct packed {
        logic [WORD_ADDR_W-1:0] addr;   // {tag, index, offset}
        logic                   write;
        logic [WORD_W-1:0]      wdata;
    } cpu_req_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        mem_op_e                op;
        logic [LINE_ADDR_W-1:0] line_addr;
        logic [LINE_W-1:0]      line;       // only used by MEM_WRITE
    } mem_req_t;

    //////////////////////////////
    // way array types
    //////////////////////////////
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] line;
    } way_rd_t;

    // a zero word_en means no write
    typedef struct packed {
        logic [WORDS_PER_LINE-1:0] word_en;
        logic                      valid;
        logic                      dirty;
        logic [TAG_W-1:0]          tag;
        logic [LINE_W-1:0]         line;
    } way_wr_t;

    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        LOOKUP      = 3'd1,
        WRITEBACK   = 3'd2,
        REFILL_REQ  = 3'd3,
        REFILL_WAIT = 3'd4,
        FILL        = 3'd5
    } ctrl_state_e;

endpackage

// ==== hw/dcache_way.sv ====
/*
 * One cache way: valid and dirty flags in flops, tag and data in plain arrays.
 * Read data appears one cycle after rd_en and holds until the next rd_en.
 * Writes take effect at the edge. A partial word_en merges words into the line.
 * A read and a write of the same set in one cycle returns the old contents.
 */
module dcache_way (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           rd_en,
    input  logic [dcache_pkg::INDEX_W-1:0] rd_index,
    input  dcache_pkg::way_wr_t            wr,
    input  logic [dcache_pkg::INDEX_W-1:0] wr_index,
    output dcache_pkg::way_rd_t            rd
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    logic [LINE_W-1:0]   data_mem [NUM_SETS];
    logic                wr_en;
    logic                rd_valid_q;
    logic                rd_dirty_q;
    logic [TAG_W-1:0]    rd_tag_q;
    logic [LINE_W-1:0]   rd_line_q;

    assign wr_en = |wr.word_en;

    //////////////////////////////
    // flags
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            rd_valid_q <= 1'b0;
            rd_dirty_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_index] <= wr.valid;
                dirty_q[wr_index] <= wr.dirty;
            end
            if (rd_en) begin
                rd_valid_q <= valid_q[rd_index];
                rd_dirty_q <= dirty_q[rd_index];
            end
        end
    end

    //////////////////////////////
    // tag and data arrays
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr.tag;
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (wr.word_en[w]) begin
                data_mem[wr_index][w*WORD_W +: WORD_W] <= wr.line[w*WORD_W +: WORD_W];
            end
        end
        if (rd_en) begin
            rd_tag_q  <= tag_mem[rd_index];
            rd_line_q <= data_mem[rd_index];
        end
    end

    assign rd = '{valid: rd_valid_q, dirty: rd_dirty_q, tag: rd_tag_q, line: rd_line_q};

endmodule

// ==== hw/dcache_way_select.sv ====
/*
 * Tag compare and victim choice for the two ways. Purely combinational.
 * Invalid ways are filled first. When both ways are valid, the LRU bit decides.
 * hit_word is only meaningful while hit is high.
 */
module dcache_way_select (
    input  dcache_pkg::way_rd_t             ways [dcache_pkg::NUM_WAYS],
    input  logic [dcache_pkg::TAG_W-1:0]    lookup_tag,
    input  logic [dcache_pkg::OFFSET_W-1:0] lookup_offset,
    input  logic                            lru_bit,
    output logic                            hit,
    output logic                            hit_way,
    output logic                            victim_way,
    output dcache_pkg::way_rd_t             victim,
    output logic [dcache_pkg::WORD_W-1:0]   hit_word
);
    import dcache_pkg::*;

    logic [NUM_WAYS-1:0] hit_vec;
    logic [LINE_W-1:0]   hit_line;

    //////////////////////////////
    // tag compare
    //////////////////////////////
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = ways[w].valid && (ways[w].tag == lookup_tag);
        end
    end

    assign hit     = |hit_vec;
    assign hit_way = hit_vec[1];      // way 0 when no hit

    //////////////////////////////
    // victim
    //////////////////////////////
    always_comb begin
        if (!ways[0].valid) begin
            victim_way = 1'b0;
        end else if (!ways[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_bit;
        end
    end

    assign victim = ways[victim_way];

    // word out of the hit line
    assign hit_line = ways[hit_way].line;
    assign hit_word = hit_line[lookup_offset*WORD_W +: WORD_W];

    // a tag lives in at most one way of a set, whatever the controller has written
    single_hit: assert final (!(hit_vec[0] === 1'b1 && hit_vec[1] === 1'b1));

endmodule

// ==== hw/dcache_ctrl.sv ====
/*
 * Miss-handling controller. It accepts a request, reads both ways, and compares
 * the tags in LOOKUP. A miss writes back a dirty victim, refills it, then responds.
 * Write misses allocate. The LRU bit per set names the way to evict next.
 * Only a read hit accepts a new request in LOOKUP. All other states stall the CPU.
 */
module dcache_ctrl (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            cpu_req_valid,
    input  dcache_pkg::cpu_req_t            cpu_req,
    output logic                            cpu_req_ready,
    output logic                            cpu_rsp_valid,
    output logic [dcache_pkg::WORD_W-1:0]   cpu_rdata,
    output logic                            mem_req_valid,
    output dcache_pkg::mem_req_t            mem_req,
    input  logic                            mem_req_ready,
    input  logic                            mem_rsp_valid,
    input  logic [dcache_pkg::LINE_W-1:0]   mem_rsp_line,
    output logic                            rd_en,
    output logic [dcache_pkg::INDEX_W-1:0]  rd_index,
    output dcache_pkg::way_wr_t             way_wr [dcache_pkg::NUM_WAYS],
    output logic [dcache_pkg::TAG_W-1:0]    lookup_tag,
    output logic [dcache_pkg::OFFSET_W-1:0] lookup_offset,
    output logic                            lru_bit,
    input  logic                            hit,
    input  logic                            hit_way,
    input  logic                            victim_way,
    input  dcache_pkg::way_rd_t             victim,
    input  logic [dcache_pkg::WORD_W-1:0]   hit_word
);
    import dcache_pkg::*;

    ctrl_state_e               state_q;
    ctrl_state_e               state_d;
    cpu_req_t                  req_q;
    logic [LINE_W-1:0]         fill_line_q;
    logic [NUM_SETS-1:0]       lru_q;
    logic [INDEX_W-1:0]        req_index;
    logic                      accept;
    logic                      lru_upd;
    logic                      lru_way;       // way just touched
    logic [WORDS_PER_LINE-1:0] word_sel;
    logic [LINE_W-1:0]         fill_merged;

    //////////////////////////////
    // request fields
    //////////////////////////////
    assign req_index     = req_q.addr[OFFSET_W +: INDEX_W];
    assign lookup_tag    = req_q.addr[WORD_ADDR_W-1 -: TAG_W];
    assign lookup_offset = req_q.addr[OFFSET_W-1:0];
    assign lru_bit       = lru_q[req_index];
    assign word_sel      = WORDS_PER_LINE'(1) << lookup_offset;

    assign accept   = cpu_req_valid && cpu_req_ready;
    assign rd_en    = accept;                          // arrays read on the accept edge
    assign rd_index = accept ? cpu_req.addr[OFFSET_W +: INDEX_W] : req_index;

    // store word goes over the refilled line on a write miss
    always_comb begin
        fill_merged = fill_line_q;
        if (req_q.write) begin
            fill_merged[lookup_offset*WORD_W +: WORD_W] = req_q.wdata;
        end
    end

    //////////////////////////////
    // FSM
    //////////////////////////////
    always_comb begin
        state_d       = state_q;
        cpu_req_ready = 1'b0;
        cpu_rsp_valid = 1'b0;
        cpu_rdata     = hit_word;
        mem_req_valid = 1'b0;
        mem_req       = '{op: MEM_READ, line_addr: req_q.addr[WORD_ADDR_W-1:OFFSET_W],
                          line: '0};
        lru_upd       = 1'b0;
        lru_way       = hit_way;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_wr[w] = '0;
        end

        case (state_q)
            IDLE: begin
                cpu_req_ready = 1'b1;
                if (cpu_req_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    cpu_rsp_valid = 1'b1;
                    lru_upd       = 1'b1;
                    if (req_q.write) begin
                        way_wr[hit_way] = '{word_en: word_sel, valid: 1'b1, dirty: 1'b1,
                                            tag: lookup_tag,
                                            line: {WORDS_PER_LINE{req_q.wdata}}};
                        state_d = IDLE;
                    end else begin
                        cpu_req_ready = 1'b1;          // next read overlaps this response
                        state_d       = cpu_req_valid ? LOOKUP : IDLE;
                    end
                end else if (victim.valid && victim.dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            WRITEBACK: begin
                mem_req_valid = 1'b1;
                mem_req       = '{op: MEM_WRITE, line_addr: {victim.tag, req_index},
                                  line: victim.line};
                if (mem_req_ready) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_rsp_valid) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                way_wr[victim_way] = '{word_en: {WORDS_PER_LINE{1'b1}}, valid: 1'b1,
                                       dirty: req_q.write, tag: lookup_tag,
                                       line: fill_merged};
                cpu_rsp_valid = 1'b1;
                cpu_rdata     = fill_line_q[lookup_offset*WORD_W +: WORD_W];
                lru_upd       = 1'b1;
                lru_way       = victim_way;
                state_d       = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            if (lru_upd) begin
                lru_q[req_index] <= ~lru_way;  // evict the other way next
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
        if (state_q == REFILL_WAIT && mem_rsp_valid) begin
            fill_line_q <= mem_rsp_line;
        end
    end

    //////////////////////////////
    // assertions
    //////////////////////////////
    mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

    // a hit answers the cycle after acceptance, a miss the cycle after the refill
    rsp_state_ok: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp_valid |-> (state_q == LOOKUP && $past(accept))
                       || (state_q == FILL && $past(mem_rsp_valid)));

endmodule

// ==== hw/dcache_top.sv ====
/*
 * Two-way set-associative write-back data cache, 256 sets of 16-byte lines.
 * The CPU holds a request until it is accepted and must take every response pulse.
 * A hit answers one cycle after acceptance. A miss waits on the memory port.
 * Each MEM_READ must get exactly one mem_rsp_valid pulse. MEM_WRITE has none.
 */
module dcache_top (
    input  logic                           clk,
    input  logic                           arst_n,
    // cpu side
    input  logic                           cpu_req_valid,
    input  dcache_pkg::cpu_req_t           cpu_req,
    output logic                           cpu_req_ready,
    output logic                           cpu_rsp_valid,
    output logic [dcache_pkg::WORD_W-1:0]  cpu_rdata,
    // next memory level
    output logic                           mem_req_valid,
    output dcache_pkg::mem_req_t           mem_req,
    input  logic                           mem_req_ready,
    input  logic                           mem_rsp_valid,
    input  logic [dcache_pkg::LINE_W-1:0]  mem_rsp_line
);
    import dcache_pkg::*;

    logic                rd_en;
    logic [INDEX_W-1:0]  rd_index;
    way_wr_t             way_wr [NUM_WAYS];
    way_rd_t             way_rd [NUM_WAYS];
    logic [TAG_W-1:0]    lookup_tag;
    logic [OFFSET_W-1:0] lookup_offset;
    logic                lru_bit;
    logic                hit;
    logic                hit_way;
    logic                victim_way;
    way_rd_t             victim;
    logic [WORD_W-1:0]   hit_word;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rdata     (cpu_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_line  (mem_rsp_line),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .way_wr        (way_wr),
        .lookup_tag    (lookup_tag),
        .lookup_offset (lookup_offset),
        .lru_bit       (lru_bit),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim        (victim),
        .hit_word      (hit_word)
    );

    // writes only happen while no new request is taken, so rd_index is the write set
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk      (clk),
            .arst_n   (arst_n),
            .rd_en    (rd_en),
            .rd_index (rd_index),
            .wr       (way_wr[w]),
            .wr_index (rd_index),
            .rd       (way_rd[w])
        );
    end

    dcache_way_select u_select (
        .ways          (way_rd),
        .lookup_tag    (lookup_tag),
        .lookup_offset (lookup_offset),
        .lru_bit       (lru_bit),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim        (victim),
        .hit_word      (hit_word)
    );

endmodule

// ==== verification/dcache_tb_mem.sv ====
/*
 * Next-level memory model for the cache testbench. Unwritten lines read as
 * word address XOR PATTERN_XOR. Ready is the inverse of stall.
 * Each read is answered RSP_DELAY cycles after its handshake, one read at a time.
 */
module dcache_tb_mem #(
    parameter int                             RSP_DELAY   = 3,
    parameter logic [dcache_pkg::WORD_W-1:0]  PATTERN_XOR = '0
) (
    input  logic                          clk,
    input  logic                          req_valid,
    input  dcache_pkg::mem_req_t          req,
    input  logic                          stall,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output logic [dcache_pkg::LINE_W-1:0] rsp_line
);
    import dcache_pkg::*;

    logic [LINE_W-1:0] lines [logic [LINE_ADDR_W-1:0]];    // written lines only
    logic              hs_seen = 1'b0;
    mem_req_t          hs_req  = '0;
    int                countdown;

    function automatic logic [LINE_W-1:0] read_line(input logic [LINE_ADDR_W-1:0] line_addr);
        logic [LINE_W-1:0] line;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*WORD_W +: WORD_W] = {2'b00, line_addr, OFFSET_W'(w)} ^ PATTERN_XOR;
        end
        return line;
    endfunction

    assign req_ready = !stall;

    // handshake sampled mid-cycle, taken at the next rising edge
    always @(negedge clk) begin
        hs_seen = req_valid && req_ready;
        hs_req  = req;
    end

    initial begin
        rsp_valid = 1'b0;
        rsp_line  = '0;
        countdown = 0;
        forever begin
            @(posedge clk);
            #1;
            rsp_valid = 1'b0;
            if (countdown > 0) begin
                countdown--;
                rsp_valid = (countdown == 0);              // single-cycle pulse
            end
            if (hs_seen && hs_req.op == MEM_WRITE) begin
                lines[hs_req.line_addr] = hs_req.line;
            end else if (hs_seen) begin
                rsp_line  = read_line(hs_req.line_addr);
                countdown = RSP_DELAY;
            end
        end
    end

endmodule

// ==== verification/dcache_tb.sv ====
/*
 * Testbench for the data cache. Concurrent assertions do all checking.
 * A shadow word array is updated when a write is accepted and predicts every read.
 * The cache keeps at most one miss open, so the memory model holds one read at a time.
 */
module dcache_tb;
    import dcache_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam logic [31:0] SEED         = 32'hdd6e11bf;
    localparam logic [31:0] PATTERN_XOR  = 32'h5ca1_ab1e;
    localparam int          MEM_DELAY    = 3;
    localparam int          DIRECTED_OPS = 16;
    localparam int          RANDOM_OPS   = 300;
    localparam int          WORST_MISS   = 8 + MEM_DELAY;  // cycles, writeback plus refill
    localparam int          TIMEOUT      = ((DIRECTED_OPS + RANDOM_OPS) * WORST_MISS * 4 + 64)
                                           * CLK_PERIOD;

    logic                   clk;
    logic                   arst_n;
    logic                   cpu_req_valid;
    cpu_req_t               cpu_req;
    logic                   cpu_req_ready;
    logic                   cpu_rsp_valid;
    logic [WORD_W-1:0]      cpu_rdata;
    logic                   mem_req_valid;
    mem_req_t               mem_req;
    logic                   mem_req_ready;
    logic                   mem_rsp_valid;
    logic [LINE_W-1:0]      mem_rsp_line;
    logic                   stall;
    logic                   bp_on;
    logic                   hit_expected;
    logic [31:0]            rng;
    logic [31:0]            bp_state;
    string                  test_name = "reset";

    // reference model state
    logic [WORD_W-1:0]      shadow [logic [WORD_ADDR_W-1:0]];
    logic [WORD_W:0]        exp_q [$];                  // {is_read, data}
    logic                   rsp_expected = 1'b1;
    logic                   exp_is_read  = 1'b0;
    logic [WORD_W-1:0]      exp_rdata    = '0;
    logic [LINE_ADDR_W-1:0] cur_line     = '0;
    logic                   read_seen    = 1'b0;
    logic                   extra_read   = 1'b0;
    logic [LINE_W-1:0]      wb_exp_line  = '0;
    int                     wb_count     = 0;

    dcache_top DUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rdata     (cpu_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_line  (mem_rsp_line)
    );

    dcache_tb_mem #(.RSP_DELAY(MEM_DELAY), .PATTERN_XOR(PATTERN_XOR)) u_mem (
        .clk       (clk),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .stall     (stall),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp_line  (mem_rsp_line)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [WORD_W-1:0] shadow_word(input logic [WORD_ADDR_W-1:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return {2'b00, addr} ^ PATTERN_XOR;                 // untouched memory pattern
    endfunction

    function automatic logic [LINE_W-1:0] shadow_line(input logic [LINE_ADDR_W-1:0] line_addr);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*WORD_W +: WORD_W] = shadow_word({line_addr, OFFSET_W'(w)});
        end
        return line;
    endfunction

    task automatic fail_stop();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic report_failure(input string what);
        $display("[%s] %s", test_name, what);
        fail_stop();
    endtask

    task automatic report_mismatch(input string what, input logic [LINE_W-1:0] exp,
                                   input logic [LINE_W-1:0] act);
        $display("ERROR [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        fail_stop();
    endtask

    // hold the request until the cache takes it
    task automatic issue(input logic write, input logic [WORD_ADDR_W-1:0] addr,
                         input logic [WORD_W-1:0] wdata, input logic expect_hit);
        cpu_req_valid = 1'b1;
        cpu_req       = '{addr: addr, write: write, wdata: wdata};
        hit_expected  = expect_hit;
        @(negedge clk);
        while (!cpu_req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
        hit_expected  = 1'b0;
    endtask

    task automatic drain();
        @(negedge clk);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // clock, back-pressure, watchdog
    //////////////////////////////
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD/2) clk = ~clk;
        end
    end

    initial begin
        stall    = 1'b0;
        bp_state = lcg_next(SEED);                          // own stream, stimulus keeps rng
        forever begin
            @(posedge clk);
            #1;
            bp_state = lcg_next(bp_state);
            stall    = bp_on && (bp_state[31:30] == 2'b11);
        end
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired after %0d time units, the cache stopped answering", TIMEOUT);
        fail_stop();
    end

    //////////////////////////////
    // monitor, mid-cycle where outputs are settled
    //////////////////////////////
    always @(negedge clk) begin
        if (cpu_rsp_valid) begin
            rsp_expected = (exp_q.size() > 0);
            if (rsp_expected) begin
                {exp_is_read, exp_rdata} = exp_q.pop_front();
            end
        end
        if (cpu_req_valid && cpu_req_ready) begin
            cur_line  = cpu_req.addr[WORD_ADDR_W-1:OFFSET_W];
            read_seen = 1'b0;
            if (cpu_req.write) begin
                shadow[cpu_req.addr] = cpu_req.wdata;
                exp_q.push_back({1'b0, cpu_req.wdata});
            end else begin
                exp_q.push_back({1'b1, shadow_word(cpu_req.addr)});
            end
        end
        if (mem_req_valid && mem_req_ready) begin
            if (mem_req.op == MEM_WRITE) begin
                wb_count++;
                wb_exp_line = shadow_line(mem_req.line_addr);
            end else begin
                extra_read = read_seen;
                read_seen  = 1'b1;
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////
    reset_state_ok: assert property (@(posedge clk)
        $rose(arst_n) |-> !cpu_rsp_valid && !mem_req_valid && cpu_req_ready)
        else report_failure("outputs are not idle right after reset");

    rsp_has_request: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp_valid |-> rsp_expected)
        else report_failure("response pulse without an open request");

    read_data_ok: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp_valid && exp_is_read |-> cpu_rdata == exp_rdata)
        else report_mismatch("read data", exp_rdata, $sampled(cpu_rdata));

    hit_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_req_valid && cpu_req_ready && hit_expected |=> cpu_rsp_valid && !mem_req_valid)
        else report_failure("hit did not respond one cycle after acceptance");

    refill_addr_ok: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && mem_req_ready && mem_req.op == MEM_READ |-> mem_req.line_addr == cur_line)
        else report_mismatch("refill line address", cur_line, $sampled(mem_req.line_addr));

    single_refill: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && mem_req_ready && mem_req.op == MEM_READ |-> !extra_read)
        else report_failure("more than one refill read for one request");

    wb_line_ok: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && mem_req_ready && mem_req.op == MEM_WRITE |-> mem_req.line == wb_exp_line)
        else report_mismatch("writeback line", wb_exp_line, $sampled(mem_req.line));

    mem_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else report_failure("mem_req changed while waiting for ready");

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        int wb_before;
        arst_n        = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        hit_expected  = 1'b0;
        bp_on         = 1'b0;
        rng           = SEED;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);                                     // idle outputs checked here
        #1;

        test_name = "cold read";
        issue(1'b0, 30'h0012_3455, '0, 1'b0);
        drain();
        test_name = "repeat read";
        issue(1'b0, 30'h0012_3455, '0, 1'b1);
        drain();

        test_name = "write then read";
        issue(1'b1, 30'h0012_3456, 32'hcafe_f00d, 1'b1);    // same line, already filled
        issue(1'b0, 30'h0012_3456, '0, 1'b1);
        issue(1'b0, 30'h0012_3454, '0, 1'b1);
        issue(1'b0, 30'h0012_3457, '0, 1'b1);
        drain();

        test_name = "eviction";
        wb_before = wb_count;
        issue(1'b1, {20'h00aa1, 8'h40, 2'd1}, 32'h1111_0001, 1'b0);
        issue(1'b1, {20'h00bb2, 8'h40, 2'd2}, 32'h2222_0002, 1'b0);
        issue(1'b1, {20'h00cc3, 8'h40, 2'd3}, 32'h3333_0003, 1'b0);
        issue(1'b0, {20'h00aa1, 8'h40, 2'd1}, '0, 1'b0);    // back through memory
        drain();
        evictions_seen: assert (wb_count == wb_before + 2)
            else report_failure("dirty lines were not written back on eviction");

        test_name = "random mix";
        bp_on     = 1'b1;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rng = lcg_next(rng);
            issue(rng[31], {18'h1_5a3c, rng[30:29], 6'h20, rng[28:27], rng[26:25]},
                  lcg_next(rng), 1'b0);
        end
        drain();
        bp_on = 1'b0;

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== dcache.f ====
hw/dcache_pkg.sv
hw/dcache_way.sv
hw/dcache_way_select.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_tb_mem.sv
verification/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - hw/dcache_pkg.sv
      - hw/dcache_way.sv
      - hw/dcache_way_select.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_top.sv
  - target: test
    files:
      - verification/dcache_tb_mem.sv
      - verification/dcache_tb.sv
